// File: common/tank_consts.svh
`ifndef TANK_CONSTS_SVH
`define TANK_CONSTS_SVH

// Every coordinate and the per-frame step share this width.
`define POS_WIDTH 10

// Tank radius and turret half-width.
`define SIZE_WIDTH 8

// Largest on-screen coordinate. Positions wrap modulo SCREEN_MAX + 1.
`define SCREEN_MAX 1023

`endif

// File: common/tankPkg.sv
package tankPkg;

    // Facing of the tank. The turret points this way.
    typedef enum logic [1:0] {
        UP,
        DOWN,
        LEFT,
        RIGHT
    } direction;

    // Lifecycle of a tank between spawn and kill.
    typedef enum logic {
        ABSENT,
        ALIVE
    } lifeState;

endpackage

// File: common/renderPkg.sv
package renderPkg;

    // Class of one pixel relative to the tank.
    typedef enum logic [1:0] {
        BACKGROUND,
        HULL,
        TURRET
    } pixelClass;

endpackage

// File: tank/tankEntity.sv
`timescale 1ns/1ps
`include "tank_consts.svh"

module tankEntity (
    input  logic                   frameClk,
    input  logic                   arstN,
    input  logic                   moveUp,
    input  logic                   moveDown,
    input  logic                   moveLeft,
    input  logic                   moveRight,
    input  logic                   sigKill,
    input  logic                   sigSpawn,
    input  logic                   sigStop,
    input  logic [`POS_WIDTH-1:0]  tankStep,
    input  logic [`POS_WIDTH-1:0]  spawnPosX,
    input  logic [`POS_WIDTH-1:0]  spawnPosY,
    output tankPkg::direction      tankDir,
    output tankPkg::lifeState      tankLife,
    output logic [`POS_WIDTH-1:0]  curPosX,
    output logic [`POS_WIDTH-1:0]  curPosY,
    output logic [`POS_WIDTH-1:0]  nextPosX,
    output logic [`POS_WIDTH-1:0]  nextPosY
);
    import tankPkg::*;

    localparam logic [`POS_WIDTH:0] posSpan = `SCREEN_MAX + 1;

    direction nextDir;
    logic [3:0] moveWord;

    function automatic logic [`POS_WIDTH-1:0] stepUp(
        input logic [`POS_WIDTH-1:0] pos,
        input logic [`POS_WIDTH-1:0] step
    );
        logic [`POS_WIDTH:0] sum;
        sum = {1'b0, pos} + {1'b0, step};
        if (sum >= posSpan) begin
            sum = sum - posSpan; // Wrap past the right or bottom edge.
        end
        return sum[`POS_WIDTH-1:0];
    endfunction

    function automatic logic [`POS_WIDTH-1:0] stepDown(
        input logic [`POS_WIDTH-1:0] pos,
        input logic [`POS_WIDTH-1:0] step
    );
        logic [`POS_WIDTH:0] diff;
        diff = {1'b0, pos} + posSpan - {1'b0, step}; // Biased so it never goes negative.
        if (diff >= posSpan) begin
            diff = diff - posSpan;
        end
        return diff[`POS_WIDTH-1:0];
    endfunction

    assign moveWord = {moveUp, moveDown, moveLeft, moveRight};

    always_comb begin
        nextPosX = curPosX;
        nextPosY = curPosY;
        nextDir  = tankDir;
        if (tankLife == ALIVE) begin
            case (moveWord)
                4'b1000: begin
                    nextPosY = stepDown(curPosY, tankStep);
                    nextDir  = UP;
                end
                4'b0100: begin
                    nextPosY = stepUp(curPosY, tankStep);
                    nextDir  = DOWN;
                end
                4'b0010: begin
                    nextPosX = stepDown(curPosX, tankStep);
                    nextDir  = LEFT;
                end
                4'b0001: begin
                    nextPosX = stepUp(curPosX, tankStep);
                    nextDir  = RIGHT;
                end
                default: ; // No move or a conflicting move word.
            endcase
        end
    end

    always_ff @(posedge frameClk or negedge arstN) begin
        if (!arstN) begin
            curPosX <= '0;
            curPosY <= '0;
        end else if (sigSpawn) begin
            curPosX <= spawnPosX;
            curPosY <= spawnPosY;
        end else if (!sigStop) begin
            curPosX <= nextPosX;
            curPosY <= nextPosY;
        end
    end

    // Facing follows the move even while stopped.
    always_ff @(posedge frameClk or negedge arstN) begin
        if (!arstN) begin
            tankDir <= RIGHT;
        end else begin
            tankDir <= nextDir;
        end
    end

    always_ff @(posedge frameClk or negedge arstN) begin
        if (!arstN) begin
            tankLife <= ABSENT;
        end else begin
            case ({sigSpawn, sigKill})
                2'b10:   tankLife <= ALIVE;
                2'b01,
                2'b11:   tankLife <= ABSENT; // Kill wins over a simultaneous spawn.
                default: tankLife <= tankLife;
            endcase
        end
    end

endmodule

// File: tank/tankMapper.sv
`timescale 1ns/1ps
`include "tank_consts.svh"

module tankMapper (
    input  logic [`POS_WIDTH-1:0]   tankPosX,
    input  logic [`POS_WIDTH-1:0]   tankPosY,
    input  logic [`POS_WIDTH-1:0]   pixelPosX,
    input  logic [`POS_WIDTH-1:0]   pixelPosY,
    input  logic [`SIZE_WIDTH-1:0]  tankRadius,
    input  logic [`SIZE_WIDTH-1:0]  turretWidth,
    input  tankPkg::direction       tankDir,
    output renderPkg::pixelClass    pixelKind
);
    import tankPkg::*;
    import renderPkg::*;

    localparam int wideW = `POS_WIDTH + 2;

    logic signed [wideW-1:0] offX;
    logic signed [wideW-1:0] offY;
    logic signed [wideW-1:0] absX;
    logic signed [wideW-1:0] absY;
    logic signed [wideW-1:0] radius;
    logic signed [wideW-1:0] halfWidth;
    logic inBox;
    logic isTurret;

    // Offsets of the pixel from the tank centre, wide enough that nothing wraps.
    assign offX = $signed({2'b00, pixelPosX}) - $signed({2'b00, tankPosX});
    assign offY = $signed({2'b00, pixelPosY}) - $signed({2'b00, tankPosY});

    assign absX = offX[wideW-1] ? -offX : offX;
    assign absY = offY[wideW-1] ? -offY : offY;

    assign radius    = $signed({{(wideW - `SIZE_WIDTH){1'b0}}, tankRadius});
    assign halfWidth = $signed({{(wideW - `SIZE_WIDTH){1'b0}}, turretWidth});

    assign inBox = (absX <= radius) && (absY <= radius);

    // Inside the hull box the far edge of each half-box is already satisfied.
    always_comb begin
        case (tankDir)
            UP:      isTurret = (absX <= halfWidth) && (offY <= 0);
            DOWN:    isTurret = (absX <= halfWidth) && (offY >= 0);
            LEFT:    isTurret = (absY <= halfWidth) && (offX <= 0);
            RIGHT:   isTurret = (absY <= halfWidth) && (offX >= 0);
            default: isTurret = 1'b0;
        endcase
    end

    always_comb begin
        if (!inBox) begin
            pixelKind = BACKGROUND;
        end else if (isTurret) begin
            pixelKind = TURRET;
        end else begin
            pixelKind = HULL;
        end
    end

endmodule

// File: tank/tank.sv
`timescale 1ns/1ps
`include "tank_consts.svh"

module tank (
    input  logic                    frameClk,
    input  logic                    arstN,
    input  logic                    moveUp,
    input  logic                    moveDown,
    input  logic                    moveLeft,
    input  logic                    moveRight,
    input  logic                    sigKill,
    input  logic                    sigSpawn,
    input  logic                    sigStop,
    input  logic [`POS_WIDTH-1:0]   tankStep,
    input  logic [`POS_WIDTH-1:0]   spawnPosX,
    input  logic [`POS_WIDTH-1:0]   spawnPosY,
    input  logic [`POS_WIDTH-1:0]   pixelPosX,
    input  logic [`POS_WIDTH-1:0]   pixelPosY,
    input  logic [`SIZE_WIDTH-1:0]  tankRadius,
    input  logic [`SIZE_WIDTH-1:0]  turretWidth,
    output tankPkg::direction       tankDir,
    output tankPkg::lifeState       tankLife,
    output logic [`POS_WIDTH-1:0]   curPosX,
    output logic [`POS_WIDTH-1:0]   curPosY,
    output logic [`POS_WIDTH-1:0]   nextPosX,
    output logic [`POS_WIDTH-1:0]   nextPosY,
    output renderPkg::pixelClass    pixelKind
);

    tankEntity tankEntity (
        .frameClk, .arstN,
        .moveUp, .moveDown, .moveLeft, .moveRight,
        .sigKill, .sigSpawn, .sigStop,
        .tankStep, .spawnPosX, .spawnPosY,
        .tankDir, .tankLife,
        .curPosX, .curPosY, .nextPosX, .nextPosY
    );

    // The mapper always draws at the registered position, alive or not.
    tankMapper tankMapper (
        .tankPosX(curPosX), .tankPosY(curPosY),
        .pixelPosX, .pixelPosY,
        .tankRadius, .turretWidth,
        .tankDir, .pixelKind
    );

endmodule

// File: tb/tank_sva.sv
`timescale 1ns/1ps
`include "tank_consts.svh"

module tankSva (
    input logic                   frameClk,
    input logic                   arstN,
    input logic                   sigSpawn,
    input logic                   sigKill,
    input logic                   sigStop,
    input tankPkg::lifeState      tankLife,
    input logic [`POS_WIDTH-1:0]  curPosX,
    input logic [`POS_WIDTH-1:0]  curPosY
);
    import tankPkg::*;

    // Spawn and kill together resolve to absent, which no driver should ask for.
    noSpawnWithKill: assert property (@(posedge frameClk) disable iff (!arstN)
        !(sigSpawn && sigKill))
        else $error("sigSpawn and sigKill were high in the same frame");

    stopHoldsPos: assert property (@(posedge frameClk) disable iff (!arstN)
        (sigStop && !sigSpawn) |=> ($stable(curPosX) && $stable(curPosY)))
        else $error("Position changed after a stop without spawn");

    absentHoldsPos: assert property (@(posedge frameClk) disable iff (!arstN)
        (tankLife == ABSENT && !sigSpawn) |=> ($stable(curPosX) && $stable(curPosY)))
        else $error("Position of an absent tank changed without spawn");

endmodule

bind tankEntity tankSva tankChecks (
    .frameClk(frameClk),
    .arstN(arstN),
    .sigSpawn(sigSpawn),
    .sigKill(sigKill),
    .sigStop(sigStop),
    .tankLife(tankLife),
    .curPosX(curPosX),
    .curPosY(curPosY)
);

// File: tb/tankTb.sv
`timescale 1ns/1ps
`include "tank_consts.svh"

module tankTb;
    import tankPkg::*;
    import renderPkg::*;

    typedef logic [`POS_WIDTH-1:0] coordT;
    typedef logic [`SIZE_WIDTH-1:0] sizeT;

    localparam int plannedFrames = 2000;
    localparam int timeoutCycles = 2 * plannedFrames;
    localparam int screenSpan = `SCREEN_MAX + 1;

    logic frameClk;
    logic arstN;
    logic moveUp;
    logic moveDown;
    logic moveLeft;
    logic moveRight;
    logic sigKill;
    logic sigSpawn;
    logic sigStop;
    coordT tankStep;
    coordT spawnPosX;
    coordT spawnPosY;
    coordT pixelPosX;
    coordT pixelPosY;
    sizeT tankRadius;
    sizeT turretWidth;
    direction tankDir;
    lifeState tankLife;
    coordT curPosX;
    coordT curPosY;
    coordT nextPosX;
    coordT nextPosY;
    pixelClass pixelKind;

    // Shadow state of the tank as the model expects it.
    coordT expPosX;
    coordT expPosY;
    direction expDir;
    lifeState expLife;

    int errorCount = 0;
    int checkCount = 0;
    int cycleCount = 0;

    tank UUT (.*);

    always #50 frameClk = ~frameClk;

    function automatic coordT wrapCoord(input coordT pos, input int delta);
        int sum;
        sum = (int'(pos) + delta) % screenSpan;
        if (sum < 0) begin
            sum = sum + screenSpan;
        end
        return coordT'(sum);
    endfunction

    // Proposed move from the shadow state and the move lines now driven.
    task automatic proposeMove(output coordT nx, output coordT ny, output direction nd);
        int lineCount;
        nx = expPosX;
        ny = expPosY;
        nd = expDir;
        lineCount = int'(moveUp) + int'(moveDown) + int'(moveLeft) + int'(moveRight);
        if (expLife == ALIVE && lineCount == 1) begin
            if (moveUp) begin
                ny = wrapCoord(expPosY, -int'(tankStep));
                nd = UP;
            end else if (moveDown) begin
                ny = wrapCoord(expPosY, int'(tankStep));
                nd = DOWN;
            end else if (moveLeft) begin
                nx = wrapCoord(expPosX, -int'(tankStep));
                nd = LEFT;
            end else begin
                nx = wrapCoord(expPosX, int'(tankStep));
                nd = RIGHT;
            end
        end
    endtask

    function automatic pixelClass classifyPixel(input coordT cx, input coordT cy,
                                                input coordT px, input coordT py,
                                                input sizeT radius, input sizeT halfWidth,
                                                input direction dir);
        int dx;
        int dy;
        int r;
        int w;
        bit turret;
        dx = int'(px) - int'(cx);
        dy = int'(py) - int'(cy);
        r = int'(radius);
        w = int'(halfWidth);
        if (dx < -r || dx > r || dy < -r || dy > r) begin
            return BACKGROUND;
        end
        case (dir)
            UP:      turret = (dx >= -w) && (dx <= w) && (dy <= 0);
            DOWN:    turret = (dx >= -w) && (dx <= w) && (dy >= 0);
            LEFT:    turret = (dy >= -w) && (dy <= w) && (dx <= 0);
            default: turret = (dy >= -w) && (dy <= w) && (dx >= 0);
        endcase
        return turret ? TURRET : HULL;
    endfunction

    task automatic applyFrame();
        coordT nx;
        coordT ny;
        direction nd;
        if (!arstN) begin
            expPosX = '0;
            expPosY = '0;
            expDir = RIGHT;
            expLife = ABSENT;
        end else begin
            proposeMove(nx, ny, nd); // Uses the life state from before this edge.
            if (sigSpawn) begin
                expPosX = spawnPosX;
                expPosY = spawnPosY;
            end else if (!sigStop) begin
                expPosX = nx;
                expPosY = ny;
            end
            expDir = nd;
            if (sigKill) begin
                expLife = ABSENT;
            end else if (sigSpawn) begin
                expLife = ALIVE;
            end
        end
    endtask

    task automatic reportMismatch(input string name, input int got, input int want);
        $display("Error at %0t ns: %s is %0d, expected %0d", $time, name, got, want);
        errorCount++;
    endtask

    task automatic checkOutputs();
        coordT nx;
        coordT ny;
        direction nd;
        pixelClass expKind;
        checkCount++;
        proposeMove(nx, ny, nd);
        expKind = classifyPixel(expPosX, expPosY, pixelPosX, pixelPosY,
                                tankRadius, turretWidth, expDir);
        if (curPosX != expPosX) reportMismatch("curPosX", int'(curPosX), int'(expPosX));
        if (curPosY != expPosY) reportMismatch("curPosY", int'(curPosY), int'(expPosY));
        if (tankDir != expDir) reportMismatch("tankDir", int'(tankDir), int'(expDir));
        if (tankLife != expLife) reportMismatch("tankLife", int'(tankLife), int'(expLife));
        if (nextPosX != nx) reportMismatch("nextPosX", int'(nextPosX), int'(nx));
        if (nextPosY != ny) reportMismatch("nextPosY", int'(nextPosY), int'(ny));
        if (pixelKind != expKind) reportMismatch("pixelKind", int'(pixelKind), int'(expKind));
    endtask

    // Inputs are stable here, half a period after the falling edge that drove them.
    always @(posedge frameClk) begin
        #1;
        applyFrame();
        checkOutputs();
    end

    always @(posedge frameClk) begin
        cycleCount++;
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic clearStrobes();
        sigSpawn = 1'b0;
        sigKill = 1'b0;
        sigStop = 1'b0;
        {moveUp, moveDown, moveLeft, moveRight} = 4'b0000;
    endtask

    task automatic pickMove();
        if ($urandom % 8 < 6) begin
            {moveUp, moveDown, moveLeft, moveRight} = 4'b0001 << ($urandom % 4);
        end else begin
            {moveUp, moveDown, moveLeft, moveRight} = 4'($urandom); // Often empty or conflicting.
        end
    endtask

    task automatic pickSizes();
        tankRadius = sizeT'(4 + $urandom % 37);
        turretWidth = sizeT'(1 + $urandom % int'(tankRadius));
    endtask

    task automatic probeNear();
        int span;
        span = 2 * int'(tankRadius) + 7;
        pixelPosX = wrapCoord(expPosX, int'($urandom % span) - int'(tankRadius) - 3);
        pixelPosY = wrapCoord(expPosY, int'($urandom % span) - int'(tankRadius) - 3);
    endtask

    task automatic spawnAt(input coordT x, input coordT y);
        sigSpawn = 1'b1;
        spawnPosX = x;
        spawnPosY = y;
    endtask

    function automatic coordT edgeCoord();
        if ($urandom % 2 == 0) begin
            return coordT'($urandom % 8);
        end
        return coordT'(`SCREEN_MAX - $urandom % 8);
    endfunction

    initial begin
        int i;
        int f;
        int roll;
        void'($urandom(95));
        frameClk = 1'b0;
        arstN = 1'b0;
        clearStrobes();
        tankStep = 1;
        spawnPosX = '0;
        spawnPosY = '0;
        pixelPosX = '0;
        pixelPosY = '0;
        tankRadius = 8;
        turretWidth = 2;
        repeat (10) @(negedge frameClk);
        arstN = 1'b1;

        // Moves must be ignored before the first spawn.
        for (f = 0; f < 40; f++) begin
            @(negedge frameClk);
            clearStrobes();
            pickMove();
            tankStep = coordT'(1 + $urandom % 16);
            probeNear();
        end

        @(negedge frameClk);
        clearStrobes();
        spawnAt(coordT'($urandom), coordT'($urandom));
        for (f = 0; f < 1600; f++) begin
            @(negedge frameClk);
            clearStrobes();
            roll = int'($urandom % 64);
            if (roll == 0) begin
                sigKill = 1'b1;
            end else if (roll == 1) begin
                spawnAt(coordT'($urandom), coordT'($urandom));
            end
            sigStop = ($urandom % 8) == 0;
            pickMove();
            if ($urandom % 16 == 0) begin
                tankStep = coordT'($urandom); // Large step to force a wrap.
            end else begin
                tankStep = coordT'($urandom % 16);
            end
            if (f % 64 == 0) begin
                pickSizes();
            end
            probeNear();
        end

        // Tanks parked at the screen edges while the facing turns.
        for (i = 0; i < 16; i++) begin
            @(negedge frameClk);
            clearStrobes();
            sigStop = 1'b1;
            spawnAt(edgeCoord(), edgeCoord());
            pickSizes();
            for (f = 0; f < 24; f++) begin
                @(negedge frameClk);
                clearStrobes();
                sigStop = 1'b1;
                pickMove();
                tankStep = coordT'(1 + $urandom % 16);
                probeNear();
            end
        end

        @(negedge frameClk);
        clearStrobes();
        repeat (2) @(negedge frameClk);
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+common
common/tankPkg.sv
common/renderPkg.sv
tank/tankEntity.sv
tank/tankMapper.sv
tank/tank.sv
tb/tank_sva.sv
tb/tankTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the tank testbench with Verilator, runs it and checks for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tankTb \
    -f project.f -Mdir obj_dir -o tankSim
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
    echo "Verilator build failed with status $buildStatus"
    exit 1
fi

simOutput=$(./obj_dir/tankSim)
simStatus=$?
echo "$simOutput"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "TEST OK" <<< "$simOutput"; then
    exit 0
fi

echo "Pass line not found in simulation output"
exit 1
